/* ctrl_pkg.sv */
package ctrl_pkg;

	typedef logic [11:0] bias_t;     // dac code
	typedef logic [4:0]  axi_addr_t; // register byte address
	typedef logic [31:0] axi_data_t;
	typedef logic [15:0] delay_t;    // stage delay in cycles

	// ------------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------------
	localparam axi_addr_t REG_CONTROL = 5'h00;
	localparam axi_addr_t REG_ISEL    = 5'h04;
	localparam axi_addr_t REG_CMPBIAS = 5'h08;
	localparam axi_addr_t REG_SBBIAS  = 5'h0c;
	localparam axi_addr_t REG_DBBIAS  = 5'h10;
	localparam axi_addr_t REG_DELAY   = 5'h14;
	localparam axi_addr_t REG_STATUS  = 5'h18; // read only

	localparam int CTRL_START = 0; // write 1 to launch the sequence
	localparam int CTRL_SKIP  = 1; // skip the bias load stage

	// status word bit positions
	localparam int STAT_DRESET = 0;
	localparam int STAT_LOADED = 1;
	localparam int STAT_TOKEN  = 2;
	localparam int STAT_BUSY   = 3;
	localparam int STAT_DROP   = 8; // drop count sits in 15:8

	// bias chain as seen by the asic
	localparam int BIAS_COUNT = 4;
	localparam int BIAS_BITS  = BIAS_COUNT * $bits(bias_t); // 48

	typedef enum logic [2:0] {
		IDLE,
		DRESET,
		LOAD,
		WAIT_LOAD,
		TOKEN,
		DONE
	} seq_state_t;

endpackage

/* alpha_pkg.sv */
package alpha_pkg;

	typedef logic [3:0]  nybble_t;
	typedef logic [15:0] word_t;

	// ------------------------------------------------------------------------
	// serial frame markers
	// ------------------------------------------------------------------------
	localparam word_t HEADER_WORD = 16'he0f1; // any bit alignment
	localparam word_t FOOTER_WORD = 16'hf00f; // word boundaries only

	// fifo sizing
	localparam int FIFO_LOG2_DEPTH = 5;
	localparam int FIFO_DEPTH      = 1 << FIFO_LOG2_DEPTH; // 32 nybbles

	typedef logic [FIFO_LOG2_DEPTH-1:0] fifo_ptr_t;
	typedef logic [7:0] drop_count_t; // saturates at 255

	typedef enum logic {
		HUNT,
		FRAME
	} rd_state_t;

endpackage

/* alpha_regs.sv */
module alpha_regs (
	input  logic                   sysclk,
	input  logic                   reset,
	input  ctrl_pkg::axi_addr_t    awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  ctrl_pkg::axi_data_t    wdata,
	input  logic [3:0]             wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  ctrl_pkg::axi_addr_t    araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output ctrl_pkg::axi_data_t    rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,
	output ctrl_pkg::bias_t        isel,
	output ctrl_pkg::bias_t        cmp_bias,
	output ctrl_pkg::bias_t        sb_bias,
	output ctrl_pkg::bias_t        db_bias,
	output ctrl_pkg::delay_t       delay,
	output logic                   skip_load,
	output logic                   start,
	input  logic                   dreset_done,
	input  logic                   bias_loaded,
	input  logic                   token_sent,
	input  logic                   shifter_busy,
	input  alpha_pkg::drop_count_t drop_count
);
	import ctrl_pkg::*;

	axi_data_t wr_word; // current value merged with the byte lanes
	logic      wr_fire;

	// current contents of a register, zero when unmapped
	function automatic axi_data_t reg_value(axi_addr_t addr);
		axi_data_t val;
		val = '0;
		case (addr)
			REG_CONTROL: val[CTRL_SKIP] = skip_load; // start bit reads 0
			REG_ISEL:    val[11:0] = isel;
			REG_CMPBIAS: val[11:0] = cmp_bias;
			REG_SBBIAS:  val[11:0] = sb_bias;
			REG_DBBIAS:  val[11:0] = db_bias;
			REG_DELAY:   val[15:0] = delay;
			REG_STATUS: begin
				val[STAT_DRESET] = dreset_done;
				val[STAT_LOADED] = bias_loaded;
				val[STAT_TOKEN] = token_sent;
				val[STAT_BUSY] = shifter_busy;
				val[STAT_DROP +: 8] = drop_count;
			end
			default: val = '0;
		endcase
		return val;
	endfunction

	always_comb begin
		wr_word = reg_value(awaddr);
		for (int b = 0; b < 4; b++) begin
			if (wstrb[b])
				wr_word[8*b +: 8] = wdata[8*b +: 8];
		end
	end

	assign wr_fire = awready & awvalid & wvalid;
	assign wready = awready; // address and data accepted together
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// ------------------------------------------------------------------------
	// write channel
	// ------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		start <= 1'b0;
		if (reset) begin
			awready <= 1'b0;
			bvalid <= 1'b0;
			isel <= '0;
			cmp_bias <= '0;
			sb_bias <= '0;
			db_bias <= '0;
			delay <= '0;
			skip_load <= 1'b0;
		end else begin
			awready <= awvalid & wvalid & ~awready & ~bvalid;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_fire) begin
				bvalid <= 1'b1;
				case (awaddr)
					REG_CONTROL: begin
						start <= wr_word[CTRL_START]; // self clearing
						skip_load <= wr_word[CTRL_SKIP];
					end
					REG_ISEL:    isel <= wr_word[11:0];
					REG_CMPBIAS: cmp_bias <= wr_word[11:0];
					REG_SBBIAS:  sb_bias <= wr_word[11:0];
					REG_DBBIAS:  db_bias <= wr_word[11:0];
					REG_DELAY:   delay <= wr_word[15:0];
					default: ; // status and holes ignore writes
				endcase
			end
		end
	end

	// read channel
	always_ff @(posedge sysclk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid & ~arready & ~rvalid;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (arready && arvalid) begin
				rvalid <= 1'b1;
				rdata <= reg_value(araddr);
			end
		end
	end

	a_bvalid_after_write: assert property (@(posedge sysclk) disable iff (reset)
		$rose(bvalid) |-> $past(awready && awvalid && wvalid));

endmodule

/* startup_sequencer.sv */
module startup_sequencer (
	input  logic             sysclk,
	input  logic             reset,
	input  logic             start,
	input  logic             skip_load,
	input  ctrl_pkg::delay_t delay,
	input  logic             load_done,
	output logic             dreset,
	output logic             load_bias,
	output logic             tok_a_in,
	output logic             dreset_done,
	output logic             bias_loaded,
	output logic             token_sent
);
	import ctrl_pkg::*;

	seq_state_t state;
	delay_t     count; // cycles of dreset still to go

	always_ff @(posedge sysclk) begin
		load_bias <= 1'b0;
		tok_a_in <= 1'b0;
		if (reset) begin
			state <= IDLE;
			dreset <= 1'b0;
			dreset_done <= 1'b0;
			bias_loaded <= 1'b0;
			token_sent <= 1'b0;
		end else begin
			case (state)
				IDLE, DONE: if (start) begin
					dreset <= 1'b1;
					count <= delay;
					dreset_done <= 1'b0; // flags restart with each run
					bias_loaded <= 1'b0;
					token_sent <= 1'b0;
					state <= DRESET;
				end
				DRESET: begin
					if (count <= 16'd1) begin
						dreset <= 1'b0;
						dreset_done <= 1'b1;
						state <= skip_load ? TOKEN : LOAD;
					end else begin
						count <= count - 1'b1;
					end
				end
				LOAD: begin
					load_bias <= 1'b1;
					state <= WAIT_LOAD;
				end
				WAIT_LOAD: if (load_done) begin
					bias_loaded <= 1'b1;
					tok_a_in <= 1'b1;
					token_sent <= 1'b1;
					state <= DONE;
				end
				TOKEN: begin // reached only when the load is skipped
					tok_a_in <= 1'b1;
					token_sent <= 1'b1;
					state <= DONE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_no_load_in_dreset: assert property (@(posedge sysclk) disable iff (reset)
		load_bias |-> !dreset);

endmodule

/* bias_shifter.sv */
module bias_shifter (
	input  logic            sysclk,
	input  logic            reset,
	input  logic            load_bias,
	input  ctrl_pkg::bias_t isel,
	input  ctrl_pkg::bias_t cmp_bias,
	input  ctrl_pkg::bias_t sb_bias,
	input  ctrl_pkg::bias_t db_bias,
	output logic            sin,
	output logic            sclk,
	output logic            pclk,
	output logic            busy,
	output logic            load_done
);
	import ctrl_pkg::*;

	logic [BIAS_BITS-1:0] shreg;
	logic [5:0]           bit_cnt; // bits already clocked
	logic                 phase;   // 1 = raise sclk next

	// ------------------------------------------------------------------------
	// two cycles per bit, sin first then sclk, then one pclk
	// ------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		sclk <= 1'b0;
		pclk <= 1'b0;
		load_done <= 1'b0;
		if (reset) begin
			sin <= 1'b0;
			busy <= 1'b0;
			phase <= 1'b0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (load_bias) begin
				shreg <= {isel, cmp_bias, sb_bias, db_bias}; // isel msb leads
				sin <= isel[11];
				bit_cnt <= '0;
				phase <= 1'b1;
				busy <= 1'b1;
			end
		end else if (phase) begin
			sclk <= 1'b1;
			shreg <= shreg << 1;
			bit_cnt <= bit_cnt + 1'b1;
			phase <= 1'b0;
		end else if (bit_cnt != 6'(BIAS_BITS)) begin
			sin <= shreg[BIAS_BITS-1];
			phase <= 1'b1;
		end else if (!pclk) begin
			pclk <= 1'b1; // latch the whole chain
			sin <= 1'b0;
		end else begin
			load_done <= 1'b1;
			busy <= 1'b0;
		end
	end

	a_sclk_pclk_apart: assert property (@(posedge sysclk) disable iff (reset)
		!(sclk && pclk));

endmodule

/* alpha_readout.sv */
module alpha_readout (
	input  logic               sysclk,
	input  logic               reset,
	input  logic               data_a,
	output alpha_pkg::nybble_t nybble,
	output logic               nybble_strobe,
	output logic               header,
	output logic               meat,
	output logic               footer,
	output logic               msn
);
	import alpha_pkg::*;

	rd_state_t  state;
	word_t      window;      // last 16 bits seen
	word_t      next_window;
	word_t      held;        // rest of the word being emitted
	logic [3:0] bit_cnt;     // position within a word
	logic [1:0] emit_left;   // nybbles still to emit

	assign next_window = {window[14:0], data_a};

	always_ff @(posedge sysclk) begin
		header <= 1'b0;
		footer <= 1'b0;
		nybble_strobe <= 1'b0;
		meat <= 1'b0;
		msn <= 1'b0;
		if (reset) begin
			state <= HUNT;
			window <= '0;
			bit_cnt <= '0;
			emit_left <= '0;
		end else begin
			window <= next_window;
			if (emit_left != 2'd0) begin
				nybble <= held[15:12];
				held <= held << 4;
				nybble_strobe <= 1'b1;
				meat <= 1'b1;
				emit_left <= emit_left - 1'b1;
			end
			case (state)
				HUNT: if (next_window == HEADER_WORD) begin
					header <= 1'b1;
					bit_cnt <= '0;
					state <= FRAME;
				end
				FRAME: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 4'd15) begin // word complete
						if (next_window == FOOTER_WORD) begin
							footer <= 1'b1;
							state <= HUNT;
						end else begin
							nybble <= next_window[15:12];
							held <= {next_window[11:0], 4'h0};
							nybble_strobe <= 1'b1;
							meat <= 1'b1;
							msn <= 1'b1;
							emit_left <= 2'd3;
						end
					end
				end
				default: state <= HUNT;
			endcase
		end
	end

endmodule

/* nybble_fifo.sv */
module nybble_fifo (
	input  logic                   sysclk,
	input  logic                   reset,
	input  alpha_pkg::nybble_t     data_in,
	input  logic                   write_enable,
	input  logic                   read_enable,
	output alpha_pkg::nybble_t     data_out,
	output logic                   empty,
	output alpha_pkg::drop_count_t drop_count
);
	import alpha_pkg::*;

	nybble_t                  mem [FIFO_DEPTH];
	fifo_ptr_t                wr_ptr;
	fifo_ptr_t                rd_ptr;
	logic [FIFO_LOG2_DEPTH:0] fill; // 0 to 32
	logic                     full;
	logic                     do_write;
	logic                     do_read;

	assign empty = (fill == '0);
	assign full = fill[FIFO_LOG2_DEPTH];
	assign do_write = write_enable & ~full;
	assign do_read = read_enable & ~empty;

	always_ff @(posedge sysclk) begin
		if (do_write)
			mem[wr_ptr] <= data_in;
		if (do_read)
			data_out <= mem[rd_ptr]; // registered output
	end

	always_ff @(posedge sysclk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			drop_count <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ;
			endcase
			if (write_enable && full && drop_count != '1)
				drop_count <= drop_count + 1'b1; // saturating
		end
	end

	a_no_read_when_empty: assert property (@(posedge sysclk) disable iff (reset)
		read_enable |-> !empty);

endmodule

/* pmod_handshake.sv */
module pmod_handshake (
	input  logic               sysclk,
	input  logic               reset,
	input  logic               fifo_empty,
	input  alpha_pkg::nybble_t fifo_data,
	input  logic               acknowledge,
	output logic               read_enable,
	output alpha_pkg::nybble_t pmod_data,
	output logic               strobe
);
	typedef enum logic [1:0] {
		PM_IDLE,
		PM_STROBE,  // strobe up, waiting for acknowledge
		PM_RELEASE  // waiting for acknowledge to drop
	} pm_state_t;

	pm_state_t state;

	assign read_enable = (state == PM_IDLE) & ~fifo_empty;
	assign pmod_data = fifo_data; // fifo output only moves on a read

	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= PM_IDLE;
			strobe <= 1'b0;
		end else begin
			case (state)
				PM_IDLE: if (read_enable) begin
					strobe <= 1'b1;
					state <= PM_STROBE;
				end
				PM_STROBE: if (acknowledge) begin
					strobe <= 1'b0;
					state <= PM_RELEASE;
				end
				PM_RELEASE: if (!acknowledge)
					state <= PM_IDLE;
				default: state <= PM_IDLE;
			endcase
		end
	end

	a_data_held: assert property (@(posedge sysclk) disable iff (reset)
		strobe && $past(strobe) |-> $stable(pmod_data));

endmodule

/* alpha_test_top.sv */
module alpha_test_top (
	input  logic                sysclk,
	input  logic                reset,
	input  ctrl_pkg::axi_addr_t awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  ctrl_pkg::axi_data_t wdata,
	input  logic [3:0]          wstrb,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	input  ctrl_pkg::axi_addr_t araddr,
	input  logic                arvalid,
	output logic                arready,
	output ctrl_pkg::axi_data_t rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,
	input  logic                data_a,
	input  logic                acknowledge,
	output alpha_pkg::nybble_t  pmod_data,
	output logic                strobe,
	output logic                dreset,
	output logic                sin,
	output logic                sclk,
	output logic                pclk,
	output logic                tok_a_in,
	output logic                header,
	output logic                meat,
	output logic                footer,
	output logic                msn
);
	import ctrl_pkg::*;
	import alpha_pkg::*;

	// ------------------------------------------------------------------------
	// control path
	// ------------------------------------------------------------------------
	bias_t       isel, cmp_bias, sb_bias, db_bias;
	delay_t      delay;
	logic        skip_load, start, load_bias, load_done, shifter_busy;
	logic        dreset_done, bias_loaded, token_sent;
	drop_count_t drop_count;

	alpha_regs regs_i (.*);

	startup_sequencer seq_i (.sysclk, .reset, .start, .skip_load, .delay, .load_done,
		.dreset, .load_bias, .tok_a_in, .dreset_done, .bias_loaded, .token_sent);

	bias_shifter shift_i (.sysclk, .reset, .load_bias, .isel, .cmp_bias, .sb_bias,
		.db_bias, .sin, .sclk, .pclk, .busy(shifter_busy), .load_done);

	// data path
	nybble_t nybble, fifo_data;
	logic    nybble_strobe, fifo_read, fifo_empty;

	alpha_readout readout_i (.sysclk, .reset, .data_a, .nybble, .nybble_strobe,
		.header, .meat, .footer, .msn);

	nybble_fifo fifo_i (.sysclk, .reset, .data_in(nybble), .write_enable(nybble_strobe),
		.read_enable(fifo_read), .data_out(fifo_data), .empty(fifo_empty), .drop_count);

	pmod_handshake pmod_i (.sysclk, .reset, .fifo_empty, .fifo_data, .acknowledge,
		.read_enable(fifo_read), .pmod_data, .strobe);

endmodule

/* tb_alpha_test.sv */
module tb_alpha_test;
	import ctrl_pkg::*;
	import alpha_pkg::*;

	localparam int TIMEOUT  = 4000;           // cycles allowed for any single wait
	localparam int BP_WORDS = 16;
	localparam int BP_KEPT  = FIFO_DEPTH + 1; // fifo plus the nybble parked on the pmod port
	localparam int QUIET    = 40;             // idle cycles in which no stray nybble may show up

	typedef struct {
		bias_t  isel;
		bias_t  cmp_bias;
		bias_t  sb_bias;
		bias_t  db_bias;
		delay_t dly;
		logic   skip;
		int     nwords;
		word_t  words [4];
	} stim_t;

	logic        sysclk = 1'b0;
	logic        reset;
	axi_addr_t   awaddr, araddr;
	axi_data_t   wdata, rdata;
	logic [3:0]  wstrb;
	logic [1:0]  bresp, rresp;
	logic        awvalid, awready, wvalid, wready, bvalid, bready;
	logic        arvalid, arready, rvalid, rready;
	logic        data_a, acknowledge, strobe;
	nybble_t     pmod_data;
	logic        dreset, sin, sclk, pclk, tok_a_in;
	logic        header, meat, footer, msn;

	stim_t       stim_table [3];
	word_t       frame_words [$];
	nybble_t     captured [$];   // nybbles seen at the pmod port
	logic        sin_bits [$];   // sin at each sclk rise
	int          dreset_cycles;
	int          pclk_pulses;
	int          header_pulses;
	int          meat_cycles;
	int          msn_pulses;
	int          strobe_rises;
	logic        sclk_seen;
	logic        pclk_seen;
	logic        strobe_seen;
	logic        ack_hold = 1'b0;
	logic [31:0] line_rng = 32'hea8c;
	logic [31:0] ack_rng = 32'hea8c;
	word_t       line_window = '0; // last 16 bits put on data_a
	int          errors = 0;
	int          err_at_start;
	int          tests_run = 0;
	int          tests_failed = 0;
	string       test_name;

	alpha_test_top dut_i (.*);

	always #10 sysclk = ~sysclk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ------------------------------------------------------------------------
	// bookkeeping and compare tasks
	// ------------------------------------------------------------------------
	task automatic finish_run();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
		errors++;
		finish_run();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == err_at_start) begin
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, errors - err_at_start);
		end
	endtask

	task automatic check_bias(input string name, input bias_t expected, input bias_t actual);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_data(input string name, input axi_data_t expected,
			input axi_data_t actual);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_nybble(input string name, input nybble_t expected,
			input nybble_t actual);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	// one header per frame, one msn and four meat cycles per payload word
	task automatic check_markers(input int words);
		check_count("header pulses", 1, header_pulses);
		check_count("msn pulses", words, msn_pulses);
		check_count("meat cycles", 4 * words, meat_cycles);
	endtask

	// ------------------------------------------------------------------------
	// axi4-lite master
	// ------------------------------------------------------------------------
	task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
		int t;
		awaddr <= addr;
		wdata <= data;
		wstrb <= 4'hf;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		for (t = 0; t <= TIMEOUT; t++) begin
			@(posedge sysclk);
			if (awready)
				break;
		end
		if (t > TIMEOUT)
			timeout_fail("awready");
		check_data("wready", 32'd1, axi_data_t'(wready)); // paired with awready
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		for (t = 0; t <= TIMEOUT; t++) begin
			@(posedge sysclk);
			if (bvalid)
				break;
		end
		if (t > TIMEOUT)
			timeout_fail("bvalid");
		check_data("bresp", '0, axi_data_t'(bresp));
	endtask

	task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
		int t;
		araddr <= addr;
		arvalid <= 1'b1;
		for (t = 0; t <= TIMEOUT; t++) begin
			@(posedge sysclk);
			if (arready)
				break;
		end
		if (t > TIMEOUT)
			timeout_fail("arready");
		arvalid <= 1'b0;
		for (t = 0; t <= TIMEOUT; t++) begin
			@(posedge sysclk);
			if (rvalid)
				break;
		end
		if (t > TIMEOUT)
			timeout_fail("rvalid");
		data = rdata;
		check_data("rresp", '0, axi_data_t'(rresp));
	endtask

	// ------------------------------------------------------------------------
	// serial frame driver
	// ------------------------------------------------------------------------
	task automatic send_bit(input logic b);
		data_a <= b;
		line_window = {line_window[14:0], b};
		@(posedge sysclk);
	endtask

	task automatic send_word(input word_t w);
		for (int i = 15; i >= 0; i--)
			send_bit(w[i]); // msb first
	endtask

	task automatic send_idle();
		int   count;
		logic b;
		line_rng = lcg_step(line_rng);
		count = 8 + int'(line_rng[31:28]);
		for (int i = 0; i < count; i++) begin
			line_rng = lcg_step(line_rng);
			b = line_rng[31];
			if ({line_window[14:0], b} == HEADER_WORD)
				b = ~b; // idle bits must not form a header
			send_bit(b);
		end
		// header starts and ends in 1, so this tail would match one bit early
		if (line_window[14:0] == HEADER_WORD[15:1])
			send_bit(1'b0);
	endtask

	task automatic send_frame();
		int t;
		header_pulses = 0;
		meat_cycles = 0;
		msn_pulses = 0;
		repeat (16)
			send_bit(1'b0); // known line history
		send_word(FOOTER_WORD); // stray footer outside a frame
		send_idle();
		send_word(HEADER_WORD);
		foreach (frame_words[i])
			send_word(frame_words[i]);
		send_word(FOOTER_WORD);
		data_a <= 1'b0;
		for (t = 0; t <= TIMEOUT; t++) begin
			@(posedge sysclk);
			if (footer)
				break;
		end
		if (t > TIMEOUT)
			timeout_fail("footer pulse");
	endtask

	task automatic wait_captured(input int count);
		int t;
		for (t = 0; t <= TIMEOUT; t++) begin
			@(posedge sysclk);
			if (captured.size() >= count)
				break;
		end
		if (t > TIMEOUT)
			timeout_fail("pmod nybbles");
		repeat (QUIET) @(posedge sysclk);
	endtask

	// acknowledge side of the pmod port, random reply gap
	initial begin : ack_responder
		int gap;
		int t;
		acknowledge = 1'b0;
		forever begin
			@(posedge sysclk);
			if (!reset && strobe === 1'b1 && !ack_hold) begin
				captured.push_back(pmod_data);
				ack_rng = lcg_step(ack_rng);
				gap = int'(ack_rng[31:30]);
				repeat (gap) @(posedge sysclk);
				acknowledge <= 1'b1;
				for (t = 0; t <= TIMEOUT; t++) begin
					@(posedge sysclk);
					if (!strobe)
						break;
				end
				if (t > TIMEOUT)
					timeout_fail("strobe release");
				acknowledge <= 1'b0;
			end
		end
	end

	always @(posedge sysclk) begin : pin_monitor
		if (!reset) begin
			if (dreset)
				dreset_cycles++;
			if (sclk && !sclk_seen)
				sin_bits.push_back(sin); // asic shifts on the sclk rise
			if (pclk && !pclk_seen)
				pclk_pulses++;
			if (strobe && !strobe_seen)
				strobe_rises++;
			if (header)
				header_pulses++;
			if (meat)
				meat_cycles++; // one cycle per nybble
			if (msn)
				msn_pulses++;
		end
		sclk_seen = sclk;
		pclk_seen = pclk;
		strobe_seen = strobe;
	end

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic test_unmapped();
		axi_data_t rd;
		begin_test("unmapped and read-only");
		axi_write(5'h1c, 32'h5a5a_a5a5);
		axi_read(5'h1c, rd);
		check_data("hole 0x1c", '0, rd);
		axi_write(REG_STATUS, 32'hffff_ffff);
		axi_read(REG_STATUS, rd);
		check_data("status after write", '0, rd); // nothing has run yet
		end_test();
	endtask

	task automatic test_registers(input int n);
		axi_data_t rd;
		begin_test($sformatf("registers, entry %0d", n));
		axi_write(REG_ISEL, axi_data_t'(stim_table[n].isel));
		axi_write(REG_CMPBIAS, axi_data_t'(stim_table[n].cmp_bias));
		axi_write(REG_SBBIAS, axi_data_t'(stim_table[n].sb_bias));
		axi_write(REG_DBBIAS, axi_data_t'(stim_table[n].db_bias));
		axi_write(REG_DELAY, axi_data_t'(stim_table[n].dly));
		axi_read(REG_ISEL, rd);
		check_bias("isel", stim_table[n].isel, rd[11:0]);
		axi_read(REG_CMPBIAS, rd);
		check_bias("cmp_bias", stim_table[n].cmp_bias, rd[11:0]);
		axi_read(REG_SBBIAS, rd);
		check_bias("sb_bias", stim_table[n].sb_bias, rd[11:0]);
		axi_read(REG_DBBIAS, rd);
		check_bias("db_bias", stim_table[n].db_bias, rd[11:0]);
		axi_read(REG_DELAY, rd);
		check_data("delay", axi_data_t'(stim_table[n].dly), rd);
		end_test();
	endtask

	task automatic test_startup(input int n);
		axi_data_t            rd;
		axi_data_t            ctrl;
		axi_data_t            exp_status;
		logic [BIAS_BITS-1:0] chain;
		int                   t;
		begin_test($sformatf("startup, entry %0d", n));
		dreset_cycles = 0;
		pclk_pulses = 0;
		sin_bits.delete();
		ctrl = '0;
		ctrl[CTRL_START] = 1'b1;
		ctrl[CTRL_SKIP] = stim_table[n].skip;
		axi_write(REG_CONTROL, ctrl);
		for (t = 0; t <= TIMEOUT; t++) begin
			@(posedge sysclk);
			if (tok_a_in)
				break;
		end
		if (t > TIMEOUT)
			timeout_fail("token pulse");
		check_count("dreset cycles", int'(stim_table[n].dly), dreset_cycles);
		check_count("pclk pulses", stim_table[n].skip ? 0 : 1, pclk_pulses);
		check_count("sclk rises", stim_table[n].skip ? 0 : BIAS_BITS, sin_bits.size());
		if (!stim_table[n].skip && sin_bits.size() == BIAS_BITS) begin
			foreach (sin_bits[i])
				chain[BIAS_BITS-1-i] = sin_bits[i];
			check_bias("sin isel", stim_table[n].isel, chain[47:36]);
			check_bias("sin cmp_bias", stim_table[n].cmp_bias, chain[35:24]);
			check_bias("sin sb_bias", stim_table[n].sb_bias, chain[23:12]);
			check_bias("sin db_bias", stim_table[n].db_bias, chain[11:0]);
		end
		exp_status = '0;
		exp_status[STAT_DRESET] = 1'b1;
		exp_status[STAT_LOADED] = !stim_table[n].skip;
		exp_status[STAT_TOKEN] = 1'b1;
		axi_read(REG_STATUS, rd);
		check_data("status", exp_status, rd);
		end_test();
	endtask

	task automatic test_readout(input int n);
		word_t got;
		begin_test($sformatf("readout, entry %0d", n));
		captured.delete();
		frame_words.delete();
		for (int i = 0; i < stim_table[n].nwords; i++)
			frame_words.push_back(stim_table[n].words[i]);
		send_frame();
		wait_captured(4 * stim_table[n].nwords);
		check_markers(stim_table[n].nwords);
		check_count("pmod nybble count", 4 * stim_table[n].nwords, captured.size());
		if (captured.size() == 4 * stim_table[n].nwords) begin
			foreach (frame_words[w]) begin
				got = {captured[4*w], captured[4*w+1], captured[4*w+2], captured[4*w+3]};
				check_word($sformatf("payload word %0d", w), frame_words[w], got);
			end
		end
		end_test();
	endtask

	task automatic test_backpressure();
		axi_data_t rd;
		word_t     w;
		nybble_t   exp_nyb;
		begin_test("backpressure");
		captured.delete();
		frame_words.delete();
		for (int i = 0; i < BP_WORDS; i++) begin
			line_rng = lcg_step(line_rng);
			w = line_rng[31:16];
			if (w == FOOTER_WORD)
				w = ~w; // would close the frame early
			frame_words.push_back(w);
		end
		ack_hold = 1'b1; // strobe is low here
		strobe_rises = 0;
		send_frame();
		check_markers(BP_WORDS);
		axi_read(REG_STATUS, rd);
		check_data("status drop count", axi_data_t'(4 * BP_WORDS - BP_KEPT) << STAT_DROP,
			rd & 32'h0000_ff00);
		check_count("strobe rises while held", 1, strobe_rises);
		check_nybble("parked nybble", nybble_t'(frame_words[0] >> 12), pmod_data);
		@(negedge sysclk);
		ack_hold = 1'b0;
		wait_captured(BP_KEPT);
		check_count("pmod nybble count", BP_KEPT, captured.size());
		if (captured.size() == BP_KEPT) begin
			foreach (captured[i]) begin
				exp_nyb = nybble_t'(frame_words[i/4] >> (12 - 4 * (i % 4)));
				check_nybble($sformatf("pmod nybble %0d", i), exp_nyb, captured[i]);
			end
		end
		end_test();
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin : stimulus
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		data_a = 1'b0;

		// isel, cmp, sb, db, delay, skip, words used, payload
		stim_table[0] = '{12'h5a3, 12'h0ff, 12'h801, 12'h3c7, 16'd7, 1'b0, 3,
			'{16'h1234, 16'habcd, 16'h0f0f, 16'h0000}};
		stim_table[1] = '{12'hfff, 12'h000, 12'h9b6, 12'h124, 16'd1, 1'b1, 1,
			'{16'he0f1, 16'h0000, 16'h0000, 16'h0000}}; // header value as payload
		stim_table[2] = '{12'h001, 12'h800, 12'h7e5, 12'hc3a, 16'd20, 1'b0, 4,
			'{16'hffff, 16'h0000, 16'hf00e, 16'h8421}};

		repeat (5) @(posedge sysclk);
		reset <= 1'b0;
		@(posedge sysclk);

		test_unmapped();
		foreach (stim_table[n]) begin
			test_registers(n);
			test_startup(n);
			test_readout(n);
		end
		test_backpressure();
		finish_run();
	end

endmodule

/* flist.f */
ctrl_pkg.sv
alpha_pkg.sv
alpha_regs.sv
startup_sequencer.sv
bias_shifter.sv
alpha_readout.sv
nybble_fifo.sv
pmod_handshake.sv
alpha_test_top.sv
tb_alpha_test.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_alpha_test -f flist.f -o sim_alpha

./obj_dir/sim_alpha | tee sim.log

grep -q "TEST PASS" sim.log
echo "simulation passed"
